// File: useq_top.f
rtl/useq_pkg.sv
rtl/useq_if.sv
rtl/useq_decode.sv
rtl/useq_regs.sv
rtl/useq_irq.sv
rtl/useq_fifo.sv
rtl/useq_core.sv
rtl/useq_top.sv
+incdir+sim
sim/useq_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP ?= useq_tb
FLIST ?= useq_top.f
BUILD_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert -j 0
PASS_MSG ?= No errors

SRCS := $(filter-out +%,$(shell cat $(FLIST)))
HDRS := $(wildcard sim/*.svh)
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM_BIN)

$(SIM_BIN): $(SRCS) $(HDRS) $(FLIST)
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

// File: sim/useq_tb_prog.svh
`ifndef USEQ_TB_PROG_SVH
`define USEQ_TB_PROG_SVH

// main program at address 0
localparam int n_main = 68;
localparam logic [data_w-1:0] prog_main [0:n_main-1] = '{
	8'h07, 8'h22, 8'h09, 8'h12,	// LDI 7, ST R2, LDI 9, ADD R2
	8'h50,	// OUT 0x10
	8'h90, 8'hF5, 8'h12, 8'h50,	// LDA F5, ADD R2, OUT 0xFC
	8'h23,	// ST R3
	8'h90, 8'h33, 8'h43, 8'h50,	// LDA 33, XOR R3, OUT 0xCF
	8'h13, 8'h50,	// ADD R3 wraps, OUT 0xCB
	8'h32, 8'h50,	// LD R2, OUT 0x07
	8'h90, 8'h5A, 8'h20,	// R0 = 5A
	8'h90, 8'hC3, 8'h21,	// R1 = C3
	8'hE2,	// EXEC2
	8'h08,	// MOV R2,R0
	8'h1D,	// ADD R3,R1
	8'h21,	// SUB R0,R1 borrows
	8'h37,	// AND R1,R3
	8'hF4,	// EXEC1
	8'h30, 8'h50, 8'h31, 8'h50,	// output R0 and R1
	8'h32, 8'h50, 8'h33, 8'h50,	// output R2 and R3
	8'hE3, 8'h71, 8'h50,	// WAITF, POP, OUT
	8'hE3, 8'h71, 8'h50,
	8'hE3, 8'h71, 8'h50,
	8'hE3, 8'h71, 8'h50,
	8'h90, 8'h11, 8'h70,	// push 11
	8'h90, 8'h22, 8'h70,	// push 22
	8'h90, 8'h9C, 8'h70,	// push 9C
	8'h50,	// OUT marks pushes done
	8'h90, 8'h04, 8'hE0,	// SEI with mask bit 2
	8'h90, 8'h3C,	// loop value
	8'h50, 8'h80, 8'h41	// 0x41: OUT, JMP 0x041
};

// ISR at isr_vect
localparam int n_isr = 4;
localparam logic [data_w-1:0] prog_isr [0:n_isr-1] = '{
	8'h90, 8'hA5, 8'h50, 8'hE1	// LDA A5, OUT, RTI
};

// o_port in order for the exec1 and exec2 part
localparam int n_out = 9;
localparam logic [data_w-1:0] exp_out [0:n_out-1] = '{
	8'h10, 8'hFC, 8'hCF, 8'hCB, 8'h07,
	8'h97, 8'h83, 8'h5A, 8'hBF
};

localparam logic [data_w-1:0] push_done = 8'h9C;	// last pushed byte, also output
localparam logic [data_w-1:0] isr_marker = 8'hA5;
localparam logic [data_w-1:0] loop_a = 8'h3C;
localparam logic [data_w-1:0] irq_bit = 8'h04;	// inside the SEI mask
localparam logic [data_w-1:0] spare_bit = 8'h01;	// outside it

// host side of the core push test
typedef struct packed {
	logic wr;	// 1 host write, 0 host read
	logic [data_w-1:0] data;
	logic [data_w-1:0] exp_out;	// fifo_out after the access
} fifo_step_t;

localparam int n_fifo_steps = 5;
localparam fifo_step_t fifo_steps [0:n_fifo_steps-1] = '{
	'{1'b0, 8'h00, 8'h11},
	'{1'b0, 8'h00, 8'h22},
	'{1'b0, 8'h00, 8'h9C},
	'{1'b1, 8'h6E, 8'h9C},	// write leaves fifo_out alone
	'{1'b0, 8'h00, 8'h6E}
};

`endif

// File: sim/useq_tb.sv
`timescale 1ns/100ps

module useq_tb import useq_pkg::*; ();

	localparam int fifo_depth = 16;
	localparam logic [addr_w-1:0] isr_vect = 10'h0F0;
	localparam int wait_limit = 200;	// cycles per wait

	`include "useq_tb_prog.svh"

	logic clk;
	logic rst_n;
	logic [data_w-1:0] mem_data;
	logic [addr_w-1:0] mem_addr;
	logic [data_w-1:0] i_port;
	logic [data_w-1:0] o_port;
	logic o_port_pulse;
	logic read_fifo;
	logic write_fifo;
	logic [data_w-1:0] fifo_in;
	logic [data_w-1:0] fifo_out;
	logic fifo_empty;
	logic fifo_full;

	logic [data_w-1:0] prog_mem [0:1023];
	logic [data_w-1:0] out_q [$];	// o_port at each pulse toggle
	logic pulse_seen;
	logic [data_w-1:0] host_data [$];	// bytes written by the host
	logic [data_w-1:0] host_byte;
	int seed_ret;

	useq_top #(.FIFO_DEPTH(fifo_depth), .ISR_VECT(isr_vect)) dut_i (
		.clk(clk),
		.rst_n(rst_n),
		.mem_data(mem_data),
		.mem_addr(mem_addr),
		.i_port(i_port),
		.o_port(o_port),
		.o_port_pulse(o_port_pulse),
		.read_fifo(read_fifo),
		.write_fifo(write_fifo),
		.fifo_in(fifo_in),
		.fifo_out(fifo_out),
		.fifo_empty(fifo_empty),
		.fifo_full(fifo_full)
	);

	always #5 clk = ~clk;

	assign mem_data = prog_mem[mem_addr];	// mem_addr only moves on rising edges

	always @(negedge clk) begin	// log every OUT, none can slip by
		if (rst_n && o_port_pulse != pulse_seen) begin
			pulse_seen = o_port_pulse;
			out_q.push_back(o_port);
		end
	end

	task automatic halt_run();
		$display("Errors found");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic check_byte(input string name, input logic [data_w-1:0] actual,
		input logic [data_w-1:0] expected);
		if (actual !== expected) begin
			$display("Fail at %0d ns: %s is %02h, expected %02h", $time, name, actual, expected);
			halt_run();
		end
	endtask

	task automatic check_flag(input string name, input logic actual, input logic expected);
		if (actual !== expected) begin
			$display("Fail at %0d ns: %s is %b, expected %b", $time, name, actual, expected);
			halt_run();
		end
	endtask

	task automatic expect_output(input logic [data_w-1:0] expected, input string what);
		int n;
		n = 0;
		while (out_q.size() == 0 && n < wait_limit) begin
			@(posedge clk);
			n++;
		end
		if (out_q.size() == 0) begin
			$display("Timeout: o_port_pulse never toggled for the %s", what);
			halt_run();
		end else begin
			check_byte("o_port", out_q.pop_front(), expected);
		end
	endtask

	task automatic host_write(input logic [data_w-1:0] data);
		@(posedge clk);
		write_fifo <= 1'b1;
		fifo_in <= data;
		@(posedge clk);
		write_fifo <= 1'b0;
		@(negedge clk);	// flags settled
	endtask

	task automatic host_read();
		@(posedge clk);
		read_fifo <= 1'b1;
		@(posedge clk);
		read_fifo <= 1'b0;
		@(negedge clk);	// fifo_out loaded one cycle after the strobe
	endtask

	task automatic load_program();
		for (int a = 0; a < 1024; a++) begin
			prog_mem[a] = 8'(a) ^ 8'(a >> 8);	// depends on all ten bits
		end
		for (int a = 0; a < n_main; a++) begin
			prog_mem[a] = prog_main[a];
		end
		for (int a = 0; a < n_isr; a++) begin
			prog_mem[int'(isr_vect) + a] = prog_isr[a];
		end
	endtask

	initial begin
		clk = 1'b0;
		rst_n = 1'b0;
		i_port = '0;
		read_fifo = 1'b0;
		write_fifo = 1'b0;
		fifo_in = '0;
		pulse_seen = 1'b0;
		seed_ret = $urandom(32'h2a88_a754);
		load_program();
		repeat (16) @(posedge clk);
		rst_n <= 1'b1;

		for (int i = 0; i < n_out; i++) begin	// exec1 then exec2 results
			expect_output(exp_out[i], "ALU output");
		end

		for (int i = 0; i < 4; i++) begin	// core sits in WAITF
			host_byte = 8'($urandom);
			host_write(host_byte);
			expect_output(host_byte, "popped FIFO byte");
		end

		@(negedge clk);
		check_flag("fifo_empty", fifo_empty, 1'b1);	// before the core pushes
		expect_output(push_done, "end of core pushes");
		@(negedge clk);
		check_flag("fifo_empty", fifo_empty, 1'b0);
		for (int i = 0; i < n_fifo_steps; i++) begin
			if (fifo_steps[i].wr) begin
				host_write(fifo_steps[i].data);
			end else begin
				host_read();
			end
			check_byte("fifo_out", fifo_out, fifo_steps[i].exp_out);
		end
		check_flag("fifo_empty", fifo_empty, 1'b1);

		host_data.delete();
		for (int i = 0; i < fifo_depth + 2; i++) begin	// last two are dropped
			host_byte = 8'($urandom);
			host_data.push_back(host_byte);
			host_write(host_byte);
			check_flag("fifo_full", fifo_full, i + 1 >= fifo_depth);
		end
		for (int i = 0; i < fifo_depth; i++) begin
			host_read();
			check_byte("fifo_out", fifo_out, host_data[i]);
		end
		check_flag("fifo_empty", fifo_empty, 1'b1);
		host_read();	// empty read
		check_byte("fifo_out", fifo_out, host_data[fifo_depth - 1]);

		@(posedge clk);
		i_port <= irq_bit;
		@(posedge clk);	// interrupt taken here, drop older loop outputs
		out_q.delete();
		expect_output(isr_marker, "ISR marker");
		expect_output(loop_a, "loop output after RTI");
		@(posedge clk);
		i_port <= irq_bit | spare_bit;
		@(posedge clk);
		out_q.delete();
		for (int i = 0; i < 4; i++) begin	// unmasked edge must not reach the ISR
			expect_output(loop_a, "loop output after unmasked edge");
		end

		$display("No errors");
		$finish;
	end

endmodule

// File: rtl/useq_top.sv
`timescale 1ns/100ps

module useq_top import useq_pkg::*; #(
	parameter int FIFO_DEPTH = 16,
	parameter logic [addr_w-1:0] ISR_VECT = 10'h0F0
) (
	input logic clk,
	input logic rst_n,
	input logic [data_w-1:0] mem_data,
	output logic [addr_w-1:0] mem_addr,
	input logic [data_w-1:0] i_port,
	output logic [data_w-1:0] o_port,
	output logic o_port_pulse,
	input logic read_fifo,
	input logic write_fifo,
	input logic [data_w-1:0] fifo_in,
	output logic [data_w-1:0] fifo_out,
	output logic fifo_empty,
	output logic fifo_full
);

	logic host_busy;	// core frozen while host uses the FIFO

	fifo_if #(.FIFO_DEPTH(FIFO_DEPTH)) ff_bus ();
	regs_if rf_bus ();
	irq_if irq_bus ();

	assign host_busy = read_fifo ^ write_fifo;	// both high counts as idle

	useq_core #(.ISR_VECT(ISR_VECT)) core_i (
		.clk(clk),
		.rst_n(rst_n),
		.host_busy(host_busy),
		.mem_data(mem_data),
		.mem_addr(mem_addr),
		.o_port(o_port),
		.o_port_pulse(o_port_pulse),
		.ff(ff_bus.source),
		.rf(rf_bus.source),
		.irq(irq_bus.source)
	);

	useq_regs regs_i (
		.clk(clk),
		.rst_n(rst_n),
		.rf(rf_bus.target)
	);

	useq_irq irq_i (
		.clk(clk),
		.rst_n(rst_n),
		.i_port(i_port),
		.irq(irq_bus.target)
	);

	useq_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) fifo_i (
		.clk(clk),
		.rst_n(rst_n),
		.read_fifo(read_fifo),
		.write_fifo(write_fifo),
		.fifo_in(fifo_in),
		.fifo_out(fifo_out),
		.fifo_empty(fifo_empty),
		.fifo_full(fifo_full),
		.ff(ff_bus.target)
	);

endmodule

// File: rtl/useq_core.sv
`timescale 1ns/100ps

module useq_core import useq_pkg::*; #(
	parameter logic [addr_w-1:0] ISR_VECT = 10'h0F0
) (
	input logic clk,
	input logic rst_n,
	input logic host_busy,	// host owns the FIFO this cycle
	input logic [data_w-1:0] mem_data,	// byte at last cycle's mem_addr
	output logic [addr_w-1:0] mem_addr,
	output logic [data_w-1:0] o_port,
	output logic o_port_pulse,	// toggles per OUT
	fifo_if.source ff,
	regs_if.source rf,
	irq_if.source irq
);

	logic [1:0] state;
	logic [addr_w-1:0] pc;
	logic [addr_w-1:0] ilr;	// return address of the ISR
	logic [data_w-1:0] acc;
	logic [data_w-1:0] saved_a;	// A across the ISR
	logic mode;	// 0 exec1, 1 exec2
	logic prev_mode;	// mode before the ISR
	insn_u insn;	// current instruction byte
	logic chain;
	logic two_byte;
	logic writes_a;
	logic is_sys;
	logic run;
	logic ex1;	// exec1 instruction really executes
	logic ex2;
	logic waitf_hold;
	logic [data_w-1:0] a_next;
	logic [data_w-1:0] alu2;

	useq_decode dec_i (
		.insn(insn),
		.mode(mode),
		.chain(chain),
		.two_byte(two_byte),
		.writes_a(writes_a),
		.is_sys(is_sys)
	);

	assign run = !host_busy;
	assign ex1 = run && !irq.trigger && state == st_exec1;	// ISR entry preempts
	assign ex2 = run && !irq.trigger && state == st_exec2;
	assign waitf_hold = !mode && is_sys && insn.e1.imm == sys_waitf && ff.count == '0;

	assign irq.run = run;
	assign irq.mask = acc;
	assign irq.mask_we = ex1 && is_sys && insn.e1.imm == sys_sei;
	assign irq.rti = ex1 && is_sys && insn.e1.imm == sys_rti;

	assign rf.ra = mode ? {2'b00, insn.e2.r} : insn.e1.imm;	// exec2 only sees R0..R3
	assign rf.sa = insn.e2.s;
	assign rf.wa = mode ? {2'b00, insn.e2.r} : insn.e1.imm;
	assign rf.wd = mode ? alu2 : acc;
	assign rf.we = (ex1 && insn.e1.op == op1_st) || (ex2 && insn.e2.op <= op2_and);
	assign rf.save = run && irq.trigger;
	assign rf.restore = irq.rti;

	assign ff.push = ex1 && insn.e1.op == op1_fifo && insn.e1.imm == 4'd0;
	assign ff.pop = ex1 && insn.e1.op == op1_fifo && insn.e1.imm == 4'd1;
	assign ff.wdata = acc;

	always_comb begin
		case (insn.e1.op)
			op1_ldi: a_next = {4'h0, insn.e1.imm};
			op1_add: a_next = acc + rf.rd;	// wraps mod 256
			op1_ld: a_next = rf.rd;
			op1_xor: a_next = acc ^ rf.rd;
			op1_in: a_next = irq.port_data;
			op1_fifo: a_next = (ff.count != '0) ? ff.rdata : acc;	// empty pop keeps A
			default: a_next = acc;
		endcase
	end

	always_comb begin
		case (insn.e2.op)
			op2_add: alu2 = rf.rd + rf.sd;
			op2_sub: alu2 = rf.rd - rf.sd;
			op2_and: alu2 = rf.rd & rf.sd;
			default: alu2 = rf.sd;	// MOV
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= st_fetch;
			pc <= '0;
			mem_addr <= '0;
			mode <= 1'b0;
			prev_mode <= 1'b0;
			o_port <= '0;
			o_port_pulse <= 1'b0;
		end else if (run) begin
			if (irq.trigger) begin	// ISR entry through a fetch
				ilr <= pc;	// unexecuted instruction reruns after RTI
				saved_a <= (state == st_loada) ? mem_data : acc;	// finish pending LDA
				prev_mode <= mode;
				mode <= 1'b0;	// ISRs run exec1
				pc <= ISR_VECT;
				mem_addr <= ISR_VECT;
				state <= st_fetch;
			end else begin
				case (state)
					st_fetch: begin
						insn <= mem_data;
						mem_addr <= pc + 1'b1;	// operand or next opcode
						state <= mode ? st_exec2 : st_exec1;
					end
					st_loada: begin
						acc <= mem_data;	// mem_addr still at the LDA operand
						mem_addr <= pc;
						state <= st_fetch;
					end
					default: begin	// st_exec1 or st_exec2
						if (writes_a) begin
							acc <= a_next;
						end
						if (!mode && insn.e1.op == op1_out) begin
							o_port <= acc;
							o_port_pulse <= ~o_port_pulse;
						end
						if (chain) begin
							pc <= pc + 1'b1;
							mem_addr <= pc + 10'd2;
							insn <= mem_data;	// next opcode already on the bus
						end else if (two_byte) begin
							if (insn.e1.op == op1_jmp) begin
								pc <= {insn.e1.imm[1:0], mem_data};
								mem_addr <= {insn.e1.imm[1:0], mem_data};
								state <= st_fetch;
							end else begin
								pc <= pc + 10'd2;	// LDA
								state <= st_loada;
							end
						end else if (!waitf_hold) begin	// sys op, WAITF stalls here
							pc <= pc + 1'b1;
							mem_addr <= pc + 1'b1;
							state <= st_fetch;
							if (mode) begin
								if ({insn.e2.r, insn.e2.s} == sys_exec1) begin
									mode <= 1'b0;
								end
							end else if (insn.e1.imm == sys_exec2) begin
								mode <= 1'b1;
							end else if (insn.e1.imm == sys_rti) begin
								pc <= ilr;
								mem_addr <= ilr;
								acc <= saved_a;
								mode <= prev_mode;
							end
						end
					end
				endcase
			end
		end
	end

	assert property (@(posedge clk) disable iff (!rst_n)
		$changed(o_port_pulse) |-> $past(state == st_exec1 || state == st_exec2))
		else $error("o_port_pulse toggled outside an execute state");

endmodule

// File: rtl/useq_fifo.sv
`timescale 1ns/100ps

module useq_fifo import useq_pkg::*; #(
	parameter int FIFO_DEPTH = 16
) (
	input logic clk,
	input logic rst_n,
	input logic read_fifo,
	input logic write_fifo,
	input logic [data_w-1:0] fifo_in,
	output logic [data_w-1:0] fifo_out,
	output logic fifo_empty,
	output logic fifo_full,
	fifo_if.target ff
);

	localparam int ptr_w = $clog2(FIFO_DEPTH);
	localparam int cnt_w = $clog2(FIFO_DEPTH + 1);

	logic [data_w-1:0] mem [0:FIFO_DEPTH-1];
	logic [ptr_w-1:0] rptr;
	logic [ptr_w-1:0] wptr;
	logic [cnt_w-1:0] count;
	logic host;	// exactly one host strobe
	logic do_push;
	logic do_pop;
	logic [data_w-1:0] push_data;

	assign host = read_fifo ^ write_fifo;
	assign do_push = (host ? write_fifo : ff.push) && !fifo_full;	// drop when full
	assign do_pop = (host ? read_fifo : ff.pop) && !fifo_empty;
	assign push_data = host ? fifo_in : ff.wdata;

	assign fifo_empty = (count == '0);
	assign fifo_full = (count == cnt_w'(FIFO_DEPTH));
	assign ff.rdata = mem[rptr];	// head, no read latency
	assign ff.count = count;

	always_ff @(posedge clk) begin
		if (do_push) begin
			mem[wptr] <= push_data;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			rptr <= '0;
			wptr <= '0;
			count <= '0;
			fifo_out <= '0;
		end else begin
			if (do_push) begin
				wptr <= (wptr == ptr_w'(FIFO_DEPTH - 1)) ? '0 : wptr + 1'b1;
			end
			if (do_pop) begin
				rptr <= (rptr == ptr_w'(FIFO_DEPTH - 1)) ? '0 : rptr + 1'b1;
			end
			if (host && read_fifo && !fifo_empty) begin
				fifo_out <= mem[rptr];	// empty read keeps old value
			end
			case ({do_push, do_pop})	// one side served per cycle
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	assert property (@(posedge clk) disable iff (!rst_n)
		count <= cnt_w'(FIFO_DEPTH))
		else $error("FIFO count above depth");

endmodule

// File: rtl/useq_irq.sv
`timescale 1ns/100ps

module useq_irq import useq_pkg::*; (
	input logic clk,
	input logic rst_n,
	input logic [data_w-1:0] i_port,
	irq_if.target irq
);

	logic [data_w-1:0] port_q;	// port as seen last running cycle
	logic [data_w-1:0] mask;	// set by SEI
	logic enable;

	// rising edge on a masked bit while enabled
	assign irq.trigger = enable && |(i_port & ~port_q & mask);
	assign irq.port_data = i_port;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			port_q <= '0;
			mask <= '0;
			enable <= 1'b0;
		end else if (irq.run) begin	// frozen during host FIFO access
			port_q <= i_port;
			if (irq.mask_we) begin
				mask <= irq.mask;
			end
			if (irq.trigger) begin
				enable <= 1'b0;	// one ISR at a time
			end else if (irq.mask_we || irq.rti) begin
				enable <= 1'b1;
			end
		end
	end

	// ISR entry preempts SEI and RTI in the core
	assert property (@(posedge clk) disable iff (!rst_n)
		irq.trigger |-> !irq.mask_we && !irq.rti)
		else $error("SEI or RTI in the cycle of an interrupt trigger");

endmodule

// File: rtl/useq_regs.sv
`timescale 1ns/100ps

module useq_regs import useq_pkg::*; (
	input logic clk,
	input logic rst_n,
	regs_if.target rf
);

	logic [data_w-1:0] r [0:15];	// R0..R15, R15 is a plain register
	logic [data_w-1:0] shadow [0:1];	// R0/R1 copy held across an ISR

	assign rf.rd = r[rf.ra];	// async read ports
	assign rf.sd = r[{2'b00, rf.sa}];

	always_ff @(posedge clk) begin
		if (rf.we) begin
			r[rf.wa] <= rf.wd;
		end
		if (rf.save) begin
			shadow[0] <= r[0];
			shadow[1] <= r[1];
		end
		if (rf.restore) begin	// last assignment so it beats we
			r[0] <= shadow[0];
			r[1] <= shadow[1];
		end
	end

	// ISR entry and RTI are separate core events
	assert property (@(posedge clk) disable iff (!rst_n)
		!(rf.save && rf.restore))
		else $error("register save and restore in the same cycle");

endmodule

// File: rtl/useq_decode.sv
`timescale 1ns/100ps

module useq_decode import useq_pkg::*; (
	input insn_u insn,
	input logic mode,	// 0 exec1, 1 exec2
	output logic chain,	// may run back to back without fetch
	output logic two_byte,	// operand in the following byte
	output logic writes_a,	// A takes the exec1 result
	output logic is_sys
);

	always_comb begin
		chain = 1'b1;	// most instructions chain
		two_byte = 1'b0;
		writes_a = 1'b0;
		is_sys = 1'b0;
		if (mode) begin
			// exec2 touches only R0..R3 and the mode
			case (insn.e2.op)
				op2_mov,
				op2_add,
				op2_sub,
				op2_and: begin
					chain = 1'b1;	// single cycle register op
				end
				op2_sys: begin
					is_sys = 1'b1;
					chain = 1'b0;	// mode change needs a realigning fetch
				end
				default: begin
					chain = 1'b1;	// unused codes act as nop
				end
			endcase
		end else begin
			case (insn.e1.op)
				op1_ldi,
				op1_add,
				op1_ld,
				op1_xor,
				op1_in: begin
					writes_a = 1'b1;
				end
				op1_fifo: begin
					writes_a = (insn.e1.imm == 4'd1);	// pop lands in A
				end
				op1_jmp,
				op1_lda: begin
					two_byte = 1'b1;
					chain = 1'b0;	// PC leaves the sequential path
				end
				op1_sys: begin
					is_sys = 1'b1;
					chain = 1'b0;
				end
				default: begin
					writes_a = 1'b0;	// ST, OUT and spare codes
				end
			endcase
		end
	end

endmodule

// File: rtl/useq_if.sv
`timescale 1ns/100ps

// core <-> message FIFO
interface fifo_if import useq_pkg::*; #(
	parameter int FIFO_DEPTH = 16
) ();
	logic push;	// write wdata if not full
	logic pop;	// drop head if not empty
	logic [data_w-1:0] wdata;
	logic [data_w-1:0] rdata;	// head entry, combinational
	logic [$clog2(FIFO_DEPTH + 1)-1:0] count;	// entries held

	modport source (output push, pop, wdata, input rdata, count);
	modport target (input push, pop, wdata, output rdata, count);
endinterface

// core <-> register file
interface regs_if import useq_pkg::*; ();
	logic [3:0] ra;	// first read address
	logic [data_w-1:0] rd;	// R[ra]
	logic [1:0] sa;	// second read address, R0..R3
	logic [data_w-1:0] sd;	// R[sa]
	logic we;
	logic [3:0] wa;
	logic [data_w-1:0] wd;
	logic save;	// R0/R1 into shadow
	logic restore;	// shadow back into R0/R1

	modport source (output ra, sa, we, wa, wd, save, restore, input rd, sd);
	modport target (input ra, sa, we, wa, wd, save, restore, output rd, sd);
endinterface

// core <-> interrupt unit
interface irq_if import useq_pkg::*; ();
	logic run;	// core not frozen by host
	logic mask_we;	// SEI
	logic [data_w-1:0] mask;
	logic rti;
	logic trigger;
	logic [data_w-1:0] port_data;	// live input port for IN

	modport source (output run, mask_we, mask, rti, input trigger, port_data);
	modport target (input run, mask_we, mask, rti, output trigger, port_data);
endinterface

// File: rtl/useq_pkg.sv
package useq_pkg;

	localparam int addr_w = 10;	// program address width
	localparam int data_w = 8;	// data path width

	// exec1 view of an instruction byte
	typedef struct packed {
		logic [3:0] op;	// opcode nibble
		logic [3:0] imm;	// immediate or register number
	} insn_e1_t;

	// exec2 view of the same byte
	typedef struct packed {
		logic [3:0] op;	// opcode nibble
		logic [1:0] r;	// destination and first source register
		logic [1:0] s;	// second source register
	} insn_e2_t;

	typedef union packed {
		insn_e1_t e1;
		insn_e2_t e2;
	} insn_u;

	// exec1 opcodes
	localparam logic [3:0] op1_ldi = 4'h0;	// A = d
	localparam logic [3:0] op1_add = 4'h1;	// A = A + R[d]
	localparam logic [3:0] op1_st = 4'h2;	// R[d] = A
	localparam logic [3:0] op1_ld = 4'h3;	// A = R[d]
	localparam logic [3:0] op1_xor = 4'h4;	// A = A ^ R[d]
	localparam logic [3:0] op1_out = 4'h5;	// o_port = A
	localparam logic [3:0] op1_in = 4'h6;	// A = i_port
	localparam logic [3:0] op1_fifo = 4'h7;	// d=0 push, d=1 pop
	localparam logic [3:0] op1_jmp = 4'h8;	// two bytes
	localparam logic [3:0] op1_lda = 4'h9;	// two bytes
	localparam logic [3:0] op1_sys = 4'hE;	// sub-code in d

	// exec2 opcodes
	localparam logic [3:0] op2_mov = 4'h0;
	localparam logic [3:0] op2_add = 4'h1;
	localparam logic [3:0] op2_sub = 4'h2;
	localparam logic [3:0] op2_and = 4'h3;
	localparam logic [3:0] op2_sys = 4'hF;	// sub-code in r:s

	// sys sub-codes
	localparam logic [3:0] sys_sei = 4'h0;	// mask from A and enable
	localparam logic [3:0] sys_rti = 4'h1;
	localparam logic [3:0] sys_exec2 = 4'h2;
	localparam logic [3:0] sys_waitf = 4'h3;	// hold while FIFO empty
	localparam logic [3:0] sys_exec1 = 4'h4;	// exec2 only

	// sequencer FSM states
	localparam logic [1:0] st_fetch = 2'd0;
	localparam logic [1:0] st_exec1 = 2'd1;
	localparam logic [1:0] st_exec2 = 2'd2;
	localparam logic [1:0] st_loada = 2'd3;	// second byte of LDA into A

endpackage
